// ==== dv/instr_decoder_testdata.txt ====
// Columns: instr priv tsr tw, then expected pipe fu_op imm flags
// Flags msb first: src1 src2 baddr irf_w late_iwb opw dc_r dc_w mem illegal ecall_m/s/u ebreak mret sret wfi
002081b3 3 0 0 1 01 0000000000000000 02000 // add x3, x1, x2
407302b3 3 0 0 1 02 0000000000000000 02000 // sub x5, x6, x7
00208033 3 0 0 1 01 0000000000000000 00000 // add x0, x1, x2
fff5851b 3 0 0 1 01 ffffffffffffffff 0a800 // addiw x10, x11, -1
43f6d613 3 0 0 1 05 000000000000043f 0a000 // srai x12, x13, 63
800000b7 3 0 0 1 0b ffffffff80000000 0a000 // lui x1, 0x80000
12345117 3 0 0 1 01 0000000012345000 1a000 // auipc x2, 0x12345
025201b3 3 0 0 2 0c 0000000000000000 02000 // mul x3, x4, x5
0283d33b 3 0 0 3 11 0000000000000000 01800 // divuw x6, x7, x8
ffdff0ef 3 0 0 4 14 fffffffffffffffc 02000 // jal x1, -4
0010006f 3 0 0 4 14 0000000000000800 00000 // jal x0, +2048
010280e7 3 0 0 4 15 0000000000000010 06000 // jalr x1, 16(x5)
010290e7 3 0 0 0 00 0000000000000010 00080 // jalr with funct3 1
fe208ce3 3 0 0 4 16 fffffffffffffff8 00000 // beq x1, x2, -8
00419863 3 0 0 4 17 0000000000000010 00000 // bne x3, x4, +16
0062c0e3 3 0 0 4 18 0000000000000800 00000 // blt x5, x6, +2048
0020d263 3 0 0 4 19 0000000000000004 00000 // bge x1, x2, +4
0020e263 3 0 0 4 1a 0000000000000004 00000 // bltu x1, x2, +4
0020f263 3 0 0 4 1b 0000000000000004 00000 // bgeu x1, x2, +4
0020a263 3 0 0 0 00 0000000000000004 00080 // branch with funct3 2
ff813503 3 0 0 5 1f fffffffffffffff8 02500 // ld x10, -8(x2)
0051c583 3 0 0 6 20 0000000000000005 02500 // lbu x11, 5(x3)
0000a003 3 0 0 5 1e 0000000000000000 00500 // lw x0, 0(x1)
fe512e23 3 0 0 5 25 fffffffffffffffc 00300 // sw x5, -4(x2)
0260b423 3 0 0 5 26 0000000000000028 00300 // sd x6, 40(x1)
0260c423 3 0 0 0 00 0000000000000028 00080 // store with funct3 4
00000073 3 0 0 7 27 0000000000000000 00040 // ecall from M
00000073 1 0 0 7 27 0000000000000000 00020 // ecall from S
00000073 0 0 0 7 27 0000000000000000 00010 // ecall from U
00100073 3 0 0 7 28 0000000000000000 00008 // ebreak
30200073 3 0 0 7 29 0000000000000000 00004 // mret from M
30200073 1 0 0 0 00 0000000000000000 00080 // mret from S
10200073 1 0 0 7 2a 0000000000000000 00002 // sret from S, tsr low
10200073 1 1 0 0 00 0000000000000000 00080 // sret from S, tsr high
10200073 3 1 0 7 2a 0000000000000000 00002 // sret from M, tsr high
10500073 3 0 1 0 00 0000000000000000 00080 // wfi, tw high
10500073 0 0 0 7 2b 0000000000000000 00001 // wfi from U, tw low
0ff0000f 3 0 0 0 00 0000000000000000 00080 // fence
00013087 3 0 0 0 00 0000000000000000 00080 // fld f1, 0(x2)
0021a0af 3 0 0 0 00 0000000000000000 00080 // amoadd.w x1, x2, (x3)
202081b3 3 0 0 0 00 0000000000000000 00080 // add with funct7 0x10
300110f3 3 0 0 0 00 0000000000000002 00080 // csrrw x1, mstatus, x2

// ==== rv_decoder.f ====
hdl/rv_decode_pkg.sv
hdl/int_op_decode.sv
hdl/ctrl_mem_decode.sv
hdl/sys_decode.sv
hdl/imm_extract.sv
hdl/instr_decoder.sv
dv/instr_decoder_tb.sv

// ==== Makefile ====
SRCS := $(wildcard hdl/*.sv dv/*.sv)

.PHONY: run clean

run: obj_dir/Vinstr_decoder_tb
	@out="$$(./obj_dir/Vinstr_decoder_tb 2>&1)"; \
	  echo "$$out"; \
	  echo "$$out" | grep -qx 'PASS: all tests'

obj_dir/Vinstr_decoder_tb: rv_decoder.f $(SRCS)
	verilator --binary --timing --assert --timescale 1ns/1ps -j 0 \
	  --top-module instr_decoder_tb -f rv_decoder.f

clean:
	rm -rf obj_dir

// ==== dv/instr_decoder_tb.sv ====
// Testbench for the registered RV64 decoder that replays file vectors with random idle gaps
module instr_decoder_tb;

  timeunit 1ns;
  timeprecision 1ps;

  localparam int fields_per_vec = 8;
  localparam int max_vecs       = 64;
  localparam int wait_limit     = 16;

  logic        clk;
  logic        rst_n;
  logic        instr_v;
  logic [31:0] instr;
  logic [1:0]  priv_mode;
  logic        tsr;
  logic        tw;

  logic        decode_v;
  logic [2:0]  pipe;
  logic [5:0]  fu_op;
  logic        src1_sel;
  logic        src2_sel;
  logic        baddr_sel;
  logic        irf_w_v;
  logic        late_iwb_v;
  logic        opw_v;
  logic        dcache_r_v;
  logic        dcache_w_v;
  logic        mem_v;
  logic        illegal_instr;
  logic        ecall_m;
  logic        ecall_s;
  logic        ecall_u;
  logic        ebreak;
  logic        mret;
  logic        sret;
  logic        wfi;
  logic [63:0] imm;

  // Eight words per vector as instr, priv, tsr, tw, pipe, fu_op, imm and flags
  logic [63:0] vec_mem [0:fields_per_vec*max_vecs-1];
  int          num_vecs;
  logic [31:0] rng_state;

  instr_decoder #(.muldiv_en_p(1'b1)) DUT
    (.clk_i            (clk)
     , .rst_n_i        (rst_n)
     , .instr_v_i      (instr_v)
     , .instr_i        (instr)
     , .priv_mode_i    (priv_mode)
     , .tsr_i          (tsr)
     , .tw_i           (tw)
     , .decode_v_o     (decode_v)
     , .pipe_o         (pipe)
     , .fu_op_o        (fu_op)
     , .src1_sel_o     (src1_sel)
     , .src2_sel_o     (src2_sel)
     , .baddr_sel_o    (baddr_sel)
     , .irf_w_v_o      (irf_w_v)
     , .late_iwb_v_o   (late_iwb_v)
     , .opw_v_o        (opw_v)
     , .dcache_r_v_o   (dcache_r_v)
     , .dcache_w_v_o   (dcache_w_v)
     , .mem_v_o        (mem_v)
     , .illegal_instr_o(illegal_instr)
     , .ecall_m_o      (ecall_m)
     , .ecall_s_o      (ecall_s)
     , .ecall_u_o      (ecall_u)
     , .ebreak_o       (ebreak)
     , .mret_o         (mret)
     , .sret_o         (sret)
     , .wfi_o          (wfi)
     , .imm_o          (imm)
    );

  always #2 clk = ~clk;

  function automatic logic [31:0] next_rand(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  // Single-bit outputs in port order with src1_sel at the top
  function automatic logic [16:0] flags_now();
    return {src1_sel, src2_sel, baddr_sel, irf_w_v, late_iwb_v, opw_v, dcache_r_v,
            dcache_w_v, mem_v, illegal_instr, ecall_m, ecall_s, ecall_u, ebreak,
            mret, sret, wfi};
  endfunction

  task automatic compare_value(input string name, input logic [63:0] expected,
                               input logic [63:0] actual);
    if (actual !== expected)
    begin
      $display("Fail %s: expected %h, actual %h", name, expected, actual);
      $display("FAIL: see errors above");
      $fatal(1);
    end
  endtask

  task automatic load_vectors();
    // Upper half of the instruction word stays nonzero where the file has no entry
    for (int a = 0; a < fields_per_vec*max_vecs; a++)
      vec_mem[a] = {32'hffff_ffff, 32'(a)};
    $readmemh("dv/instr_decoder_testdata.txt", vec_mem);
    num_vecs = 0;
    while ((num_vecs < max_vecs) && (vec_mem[num_vecs*fields_per_vec][63:32] == 32'h0))
      num_vecs++;
    if (num_vecs == 0)
    begin
      $display("No vectors could be read from the test data file");
      $display("FAIL: see errors above");
      $fatal(1);
    end
  endtask

  task automatic drive_vectors();
    int base;
    int gap;
    for (int i = 0; i < num_vecs; i++)
    begin
      base = i * fields_per_vec;
      @(posedge clk);
      instr_v   <= 1'b1;
      instr     <= vec_mem[base][31:0];
      priv_mode <= vec_mem[base+1][1:0];
      tsr       <= vec_mem[base+2][0];
      tw        <= vec_mem[base+3][0];
      rng_state = next_rand(rng_state);
      gap = int'(rng_state % 32'd4);
      repeat (gap)
      begin
        @(posedge clk);
        instr_v <= 1'b0;
      end
    end
    @(posedge clk);
    instr_v <= 1'b0;
  endtask

  task automatic check_vectors();
    int    base;
    int    waited;
    string tag;
    for (int i = 0; i < num_vecs; i++)
    begin
      base   = i * fields_per_vec;
      waited = 0;
      do
      begin
        @(negedge clk);
        waited++;
        if (waited > wait_limit)
        begin
          $display("Timed out waiting for decode_v_o on vector %0d", i);
          $display("FAIL: see errors above");
          $fatal(1);
        end
      end
      while (!decode_v);
      tag = $sformatf("vector %0d (instr %h)", i, vec_mem[base][31:0]);
      compare_value({tag, " pipe"}, vec_mem[base+4], 64'(pipe));
      compare_value({tag, " fu_op"}, vec_mem[base+5], 64'(fu_op));
      compare_value({tag, " imm"}, vec_mem[base+6], imm);
      compare_value({tag, " flags"}, vec_mem[base+7], 64'(flags_now()));
    end
  endtask

  initial
  begin
    clk       = 1'b0;
    rst_n     = 1'b0;
    instr_v   = 1'b0;
    instr     = 32'h0;
    priv_mode = 2'd3;
    tsr       = 1'b0;
    tw        = 1'b0;
    rng_state = 32'ha75f;
    load_vectors();
    repeat (2) @(posedge clk);
    rst_n <= 1'b1;
    // Reset state must hold until the first strobe
    @(negedge clk);
    compare_value("reset decode_v", 64'd0, 64'(decode_v));
    compare_value("reset pipe", 64'd0, 64'(pipe));
    compare_value("reset imm", 64'd0, imm);
    compare_value("reset flags", 64'd0, 64'(flags_now()));
    fork
      drive_vectors();
      check_vectors();
    join
    $display("PASS: all tests");
    $finish;
  end

endmodule

// ==== hdl/instr_decoder.sv ====
// Registered RV64 decode stage merging the sub-decoders into one set of pipeline controls
module instr_decoder
  #(parameter bit muldiv_en_p = 1'b1)
  (input  logic                        clk_i
   , input  logic                      rst_n_i
   , input  logic                      instr_v_i
   , input  rv_decode_pkg::instr_t     instr_i
   , input  rv_decode_pkg::priv_mode_t priv_mode_i
   , input  logic                      tsr_i
   , input  logic                      tw_i
   , output logic                      decode_v_o
   , output rv_decode_pkg::pipe_e      pipe_o
   , output rv_decode_pkg::fu_op_e     fu_op_o
   , output rv_decode_pkg::src1_sel_e  src1_sel_o
   , output rv_decode_pkg::src2_sel_e  src2_sel_o
   , output rv_decode_pkg::baddr_sel_e baddr_sel_o
   , output logic                      irf_w_v_o
   , output logic                      late_iwb_v_o
   , output logic                      opw_v_o
   , output logic                      dcache_r_v_o
   , output logic                      dcache_w_v_o
   , output logic                      mem_v_o
   , output logic                      illegal_instr_o
   , output logic                      ecall_m_o
   , output logic                      ecall_s_o
   , output logic                      ecall_u_o
   , output logic                      ebreak_o
   , output logic                      mret_o
   , output logic                      sret_o
   , output logic                      wfi_o
   , output rv_decode_pkg::dword_t     imm_o
  );

  import rv_decode_pkg::*;

  logic       int_claim, int_illegal, int_irf_w_v, int_late_iwb_v, int_opw_v;
  pipe_e      int_pipe;
  fu_op_e     int_fu_op;
  src1_sel_e  int_src1_sel;
  src2_sel_e  int_src2_sel;

  logic       cm_claim, cm_illegal, cm_irf_w_v, cm_dcache_r_v, cm_dcache_w_v, cm_mem_v;
  pipe_e      cm_pipe;
  fu_op_e     cm_fu_op;
  baddr_sel_e cm_baddr_sel;

  logic       sys_claim, sys_illegal, sys_ecall_m, sys_ecall_s, sys_ecall_u;
  logic       sys_ebreak, sys_mret, sys_sret, sys_wfi;
  fu_op_e     sys_fu_op;

  dword_t     imm_d;
  logic       legal_d;
  pipe_e      pipe_d;
  fu_op_e     fu_op_d;

  int_op_decode #(.muldiv_en_p(muldiv_en_p)) int_dec
    (.instr_i      (instr_i)
     , .claim_o    (int_claim)
     , .illegal_o  (int_illegal)
     , .irf_w_v_o  (int_irf_w_v)
     , .late_iwb_v_o(int_late_iwb_v)
     , .opw_v_o    (int_opw_v)
     , .pipe_o     (int_pipe)
     , .fu_op_o    (int_fu_op)
     , .src1_sel_o (int_src1_sel)
     , .src2_sel_o (int_src2_sel)
    );

  ctrl_mem_decode cm_dec
    (.instr_i       (instr_i)
     , .claim_o     (cm_claim)
     , .illegal_o   (cm_illegal)
     , .irf_w_v_o   (cm_irf_w_v)
     , .dcache_r_v_o(cm_dcache_r_v)
     , .dcache_w_v_o(cm_dcache_w_v)
     , .mem_v_o     (cm_mem_v)
     , .pipe_o      (cm_pipe)
     , .fu_op_o     (cm_fu_op)
     , .baddr_sel_o (cm_baddr_sel)
    );

  sys_decode sys_dec
    (.instr_i      (instr_i)
     , .priv_mode_i(priv_mode_i)
     , .tsr_i      (tsr_i)
     , .tw_i       (tw_i)
     , .claim_o    (sys_claim)
     , .illegal_o  (sys_illegal)
     , .ecall_m_o  (sys_ecall_m)
     , .ecall_s_o  (sys_ecall_s)
     , .ecall_u_o  (sys_ecall_u)
     , .ebreak_o   (sys_ebreak)
     , .mret_o     (sys_mret)
     , .sret_o     (sys_sret)
     , .wfi_o      (sys_wfi)
     , .fu_op_o    (sys_fu_op)
    );

  imm_extract imm_ext
    (.instr_i (instr_i)
     , .imm_o (imm_d)
    );

  // Unclaimed opcodes (FENCE, FP, AMO and the like) land here as illegal
  assign legal_d = (int_claim || cm_claim || sys_claim)
                   && !(int_illegal || cm_illegal || sys_illegal);

  // An illegal instruction issues to no pipe
  always_comb
  begin
    pipe_d  = pipe_none;
    fu_op_d = op_none;
    if (legal_d)
    begin
      if (int_claim)
      begin
        pipe_d  = int_pipe;
        fu_op_d = int_fu_op;
      end
      else if (cm_claim)
      begin
        pipe_d  = cm_pipe;
        fu_op_d = cm_fu_op;
      end
      else
      begin
        pipe_d  = pipe_sys;
        fu_op_d = sys_fu_op;
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      decode_v_o      <= 1'b0;
      pipe_o          <= pipe_none;
      fu_op_o         <= op_none;
      src1_sel_o      <= src1_rs1;
      src2_sel_o      <= src2_rs2;
      baddr_sel_o     <= baddr_pc;
      irf_w_v_o       <= 1'b0;
      late_iwb_v_o    <= 1'b0;
      opw_v_o         <= 1'b0;
      dcache_r_v_o    <= 1'b0;
      dcache_w_v_o    <= 1'b0;
      mem_v_o         <= 1'b0;
      illegal_instr_o <= 1'b0;
      ecall_m_o       <= 1'b0;
      ecall_s_o       <= 1'b0;
      ecall_u_o       <= 1'b0;
      ebreak_o        <= 1'b0;
      mret_o          <= 1'b0;
      sret_o          <= 1'b0;
      wfi_o           <= 1'b0;
      imm_o           <= '0;
    end
    else
    begin
      decode_v_o <= instr_v_i;
      // Hold the last decode between strobes
      if (instr_v_i)
      begin
        pipe_o          <= pipe_d;
        fu_op_o         <= fu_op_d;
        src1_sel_o      <= legal_d ? int_src1_sel : src1_rs1;
        src2_sel_o      <= legal_d ? int_src2_sel : src2_rs2;
        baddr_sel_o     <= legal_d ? cm_baddr_sel : baddr_pc;
        irf_w_v_o       <= legal_d && (int_irf_w_v || cm_irf_w_v);
        late_iwb_v_o    <= legal_d && int_late_iwb_v;
        opw_v_o         <= legal_d && int_opw_v;
        dcache_r_v_o    <= legal_d && cm_dcache_r_v;
        dcache_w_v_o    <= legal_d && cm_dcache_w_v;
        mem_v_o         <= legal_d && cm_mem_v;
        illegal_instr_o <= !legal_d;
        ecall_m_o       <= sys_ecall_m;
        ecall_s_o       <= sys_ecall_s;
        ecall_u_o       <= sys_ecall_u;
        ebreak_o        <= sys_ebreak;
        mret_o          <= sys_mret;
        sret_o          <= sys_sret;
        wfi_o           <= sys_wfi;
        imm_o           <= imm_d;
      end
    end
  end

  // Opcode ownership across the three sub-decoders must not overlap
  claim_onehot_a: assert property (@(posedge clk_i) disable iff (!rst_n_i)
                                   instr_v_i |-> $onehot0({int_claim, cm_claim, sys_claim}))
    else $error("instr_decoder: more than one sub-decoder claimed the opcode");

endmodule

// ==== hdl/imm_extract.sv ====
// Immediate extraction with sign extension to 64 bits in the format chosen by the major opcode
module imm_extract
  (input  rv_decode_pkg::instr_t   instr_i
   , output rv_decode_pkg::dword_t imm_o
  );

  import rv_decode_pkg::*;

  opcode_t   opcode;
  reg_addr_t rs1_addr;
  logic      sign;

  assign opcode   = instr_i[6:0];
  assign rs1_addr = instr_i[19:15];
  assign sign     = instr_i[31];

  always_comb
  begin
    case (opcode)
      lui_op, auipc_op:
        imm_o = {{32{sign}}, instr_i[31:12], 12'b0};
      jal_op:
        imm_o = {{44{sign}}, instr_i[19:12], instr_i[20], instr_i[30:21], 1'b0};
      branch_op:
        imm_o = {{52{sign}}, instr_i[7], instr_i[30:25], instr_i[11:8], 1'b0};
      store_op:
        imm_o = {{53{sign}}, instr_i[30:25], instr_i[11:7]};
      jalr_op, load_op, op_imm_op, op_imm_32_op:
        imm_o = {{53{sign}}, instr_i[30:20]};
      // CSR-style uimm from the rs1 field
      system_op:
        imm_o = {59'b0, rs1_addr};
      default:
        imm_o = '0;
    endcase
  end

endmodule

// ==== hdl/sys_decode.sv ====
// SYSTEM opcode decoder for ECALL, EBREAK, MRET, SRET and WFI with privilege checks
module sys_decode
  (input  rv_decode_pkg::instr_t     instr_i
   , input  rv_decode_pkg::priv_mode_t priv_mode_i
   , input  logic                    tsr_i
   , input  logic                    tw_i
   , output logic                    claim_o
   , output logic                    illegal_o
   , output logic                    ecall_m_o
   , output logic                    ecall_s_o
   , output logic                    ecall_u_o
   , output logic                    ebreak_o
   , output logic                    mret_o
   , output logic                    sret_o
   , output logic                    wfi_o
   , output rv_decode_pkg::fu_op_e   fu_op_o
  );

  import rv_decode_pkg::*;

  // Full encodings with every field fixed
  localparam instr_t ecall_instr  = 32'h0000_0073;
  localparam instr_t ebreak_instr = 32'h0010_0073;
  localparam instr_t sret_instr   = 32'h1020_0073;
  localparam instr_t wfi_instr    = 32'h1050_0073;
  localparam instr_t mret_instr   = 32'h3020_0073;

  assign claim_o = (instr_i[6:0] == system_op);

  always_comb
  begin
    illegal_o = 1'b0;
    ecall_m_o = 1'b0;
    ecall_s_o = 1'b0;
    ecall_u_o = 1'b0;
    ebreak_o  = 1'b0;
    mret_o    = 1'b0;
    sret_o    = 1'b0;
    wfi_o     = 1'b0;
    fu_op_o   = op_none;
    if (claim_o)
    begin
      case (instr_i)
        ecall_instr:
        begin
          fu_op_o   = op_ecall;
          ecall_m_o = (priv_mode_i == priv_m);
          ecall_s_o = (priv_mode_i == priv_s);
          ecall_u_o = (priv_mode_i == priv_u);
        end
        ebreak_instr:
        begin
          fu_op_o  = op_ebreak;
          ebreak_o = 1'b1;
        end
        mret_instr:
        begin
          fu_op_o   = op_mret;
          illegal_o = (priv_mode_i < priv_m);
          mret_o    = (priv_mode_i == priv_m);
        end
        sret_instr:
        begin
          fu_op_o   = op_sret;
          // TSR traps SRET from S mode into M
          illegal_o = (priv_mode_i < priv_s) || (tsr_i && (priv_mode_i == priv_s));
          sret_o    = (priv_mode_i > priv_s) || (!tsr_i && (priv_mode_i == priv_s));
        end
        wfi_instr:
        begin
          fu_op_o   = op_wfi;
          illegal_o = tw_i;
          wfi_o     = !tw_i;
        end
        default: illegal_o = 1'b1;
      endcase
    end
    ret_legal_a: assert (!(illegal_o && (mret_o || sret_o || wfi_o)))
      else $error("sys_decode: return or WFI flagged on an illegal instruction");
  end

endmodule

// ==== hdl/ctrl_mem_decode.sv ====
// Jump, branch, integer load and integer store decoder
module ctrl_mem_decode
  (input  rv_decode_pkg::instr_t       instr_i
   , output logic                      claim_o
   , output logic                      illegal_o
   , output logic                      irf_w_v_o
   , output logic                      dcache_r_v_o
   , output logic                      dcache_w_v_o
   , output logic                      mem_v_o
   , output rv_decode_pkg::pipe_e      pipe_o
   , output rv_decode_pkg::fu_op_e     fu_op_o
   , output rv_decode_pkg::baddr_sel_e baddr_sel_o
  );

  import rv_decode_pkg::*;

  opcode_t    opcode;
  reg_addr_t  rd_addr;
  logic [2:0] funct3;
  logic       rd_nz;

  assign opcode  = instr_i[6:0];
  assign rd_addr = instr_i[11:7];
  assign funct3  = instr_i[14:12];
  assign rd_nz   = (rd_addr != '0);

  always_comb
  begin
    claim_o      = 1'b0;
    illegal_o    = 1'b0;
    irf_w_v_o    = 1'b0;
    dcache_r_v_o = 1'b0;
    dcache_w_v_o = 1'b0;
    mem_v_o      = 1'b0;
    pipe_o       = pipe_none;
    fu_op_o      = op_none;
    baddr_sel_o  = baddr_pc;
    case (opcode)
      jal_op:
      begin
        claim_o   = 1'b1;
        pipe_o    = pipe_ctl;
        irf_w_v_o = rd_nz;
        fu_op_o   = op_jal;
      end
      jalr_op:
      begin
        claim_o     = 1'b1;
        pipe_o      = pipe_ctl;
        irf_w_v_o   = rd_nz;
        fu_op_o     = op_jalr;
        baddr_sel_o = baddr_rs1;
        illegal_o   = (funct3 != 3'd0);
      end
      branch_op:
      begin
        claim_o = 1'b1;
        pipe_o  = pipe_ctl;
        case (funct3)
          3'd0:    fu_op_o = op_beq;
          3'd1:    fu_op_o = op_bne;
          3'd4:    fu_op_o = op_blt;
          3'd5:    fu_op_o = op_bge;
          3'd6:    fu_op_o = op_bltu;
          3'd7:    fu_op_o = op_bgeu;
          default: illegal_o = 1'b1;
        endcase
      end
      load_op:
      begin
        claim_o      = 1'b1;
        irf_w_v_o    = rd_nz;
        dcache_r_v_o = 1'b1;
        mem_v_o      = 1'b1;
        // Full-word loads skip the extension step
        pipe_o = (funct3 inside {3'd2, 3'd3, 3'd6}) ? pipe_mem_early : pipe_mem_final;
        if (funct3 == 3'd7)
          illegal_o = 1'b1;
        else
          fu_op_o = fu_op_e'(op_lb + 6'(funct3));
      end
      store_op:
      begin
        claim_o      = 1'b1;
        pipe_o       = pipe_mem_early;
        dcache_w_v_o = 1'b1;
        mem_v_o      = 1'b1;
        if (funct3[2])
          illegal_o = 1'b1;
        else
          fu_op_o = fu_op_e'(op_sb + 6'(funct3));
      end
      default: claim_o = 1'b0;
    endcase
  end

endmodule

// ==== hdl/int_op_decode.sv ====
// Integer ALU and multiply/divide decoder for OP, OP-32, OP-IMM, OP-IMM-32, LUI and AUIPC
module int_op_decode
  #(parameter bit muldiv_en_p = 1'b1)
  (input  rv_decode_pkg::instr_t      instr_i
   , output logic                     claim_o
   , output logic                     illegal_o
   , output logic                     irf_w_v_o
   , output logic                     late_iwb_v_o
   , output logic                     opw_v_o
   , output rv_decode_pkg::pipe_e     pipe_o
   , output rv_decode_pkg::fu_op_e    fu_op_o
   , output rv_decode_pkg::src1_sel_e src1_sel_o
   , output rv_decode_pkg::src2_sel_e src2_sel_o
  );

  import rv_decode_pkg::*;

  opcode_t    opcode;
  reg_addr_t  rd_addr;
  logic [2:0] funct3;
  logic [6:0] funct7;
  logic       rd_nz;
  logic       is_w;
  logic       is_muldiv;
  logic       shift_l_ok;
  logic       shift_ra_ok;

  assign opcode    = instr_i[6:0];
  assign rd_addr   = instr_i[11:7];
  assign funct3    = instr_i[14:12];
  assign funct7    = instr_i[31:25];
  assign rd_nz     = (rd_addr != '0);
  assign is_w      = (opcode == op_32_op) || (opcode == op_imm_32_op);
  assign is_muldiv = (funct7 == 7'b0000001);

  // RV64 shifts take a 6-bit shamt and the W forms only 5 bits
  assign shift_l_ok  = is_w ? (funct7 == 7'b0000000) : (instr_i[31:26] == 6'b000000);
  assign shift_ra_ok = is_w ? (funct7 == 7'b0100000) : (instr_i[31:26] == 6'b010000);

  always_comb
  begin
    claim_o      = 1'b0;
    illegal_o    = 1'b0;
    irf_w_v_o    = 1'b0;
    late_iwb_v_o = 1'b0;
    opw_v_o      = 1'b0;
    pipe_o       = pipe_none;
    fu_op_o      = op_none;
    src1_sel_o   = src1_rs1;
    src2_sel_o   = src2_rs2;
    case (opcode)
      op_op, op_32_op:
      begin
        claim_o = 1'b1;
        opw_v_o = is_w;
        case (funct7)
          7'b0000000:
            case (funct3)
              3'd0:    fu_op_o = op_add;
              3'd1:    fu_op_o = op_sll;
              3'd2:    fu_op_o = op_slt;
              3'd3:    fu_op_o = op_sltu;
              3'd4:    fu_op_o = op_xor;
              3'd5:    fu_op_o = op_srl;
              3'd6:    fu_op_o = op_or;
              default: fu_op_o = op_and;
            endcase
          7'b0100000:
            case (funct3)
              3'd0:    fu_op_o = op_sub;
              3'd5:    fu_op_o = op_sra;
              default: illegal_o = 1'b1;
            endcase
          7'b0000001:
          begin
            fu_op_o   = fu_op_e'(op_imul + 6'(funct3));
            illegal_o = !muldiv_en_p;
          end
          default: illegal_o = 1'b1;
        endcase
        // No W form for compares, logic ops or the high multiplies
        if (is_w && (fu_op_o inside {op_slt, op_sltu, op_xor, op_or, op_and,
                                     op_mulh, op_mulhsu, op_mulhu}))
          illegal_o = 1'b1;
        if (is_muldiv)
          pipe_o = (fu_op_o == op_imul) ? pipe_mul : pipe_long;
        else
          pipe_o = pipe_int;
        // Divides and high multiplies write back out of band
        late_iwb_v_o = rd_nz && (fu_op_o inside {op_mulh, op_mulhsu, op_mulhu,
                                                 op_div, op_divu, op_rem, op_remu});
        irf_w_v_o    = rd_nz && (pipe_o != pipe_long);
      end
      op_imm_op, op_imm_32_op:
      begin
        claim_o    = 1'b1;
        opw_v_o    = is_w;
        pipe_o     = pipe_int;
        irf_w_v_o  = rd_nz;
        src2_sel_o = src2_imm;
        case (funct3)
          3'd0: fu_op_o = op_add;
          3'd1:
          begin
            fu_op_o   = op_sll;
            illegal_o = !shift_l_ok;
          end
          3'd2: fu_op_o = op_slt;
          3'd3: fu_op_o = op_sltu;
          3'd4: fu_op_o = op_xor;
          3'd5:
          begin
            fu_op_o   = shift_ra_ok ? op_sra : op_srl;
            illegal_o = !(shift_l_ok || shift_ra_ok);
          end
          3'd6:    fu_op_o = op_or;
          default: fu_op_o = op_and;
        endcase
        if (is_w && !(funct3 inside {3'd0, 3'd1, 3'd5}))
          illegal_o = 1'b1;
      end
      lui_op:
      begin
        claim_o    = 1'b1;
        pipe_o     = pipe_int;
        irf_w_v_o  = rd_nz;
        fu_op_o    = op_pass_src2;
        src2_sel_o = src2_imm;
      end
      auipc_op:
      begin
        claim_o    = 1'b1;
        pipe_o     = pipe_int;
        irf_w_v_o  = rd_nz;
        fu_op_o    = op_add;
        src1_sel_o = src1_pc;
        src2_sel_o = src2_imm;
      end
      default: claim_o = 1'b0;
    endcase
    writeback_excl_a: assert (!(irf_w_v_o && late_iwb_v_o))
      else $error("int_op_decode: both regular and late writeback requested");
  end

endmodule

// ==== hdl/rv_decode_pkg.sv ====
// RV64 decode package with instruction field types, major opcodes and operation encodings
package rv_decode_pkg;

  typedef logic [31:0] instr_t;
  typedef logic [63:0] dword_t;
  typedef logic [6:0]  opcode_t;
  typedef logic [4:0]  reg_addr_t;
  typedef logic [1:0]  priv_mode_t;

  // Privilege levels as held in mstatus.MPP
  localparam priv_mode_t priv_m = 2'd3;
  localparam priv_mode_t priv_s = 2'd1;
  localparam priv_mode_t priv_u = 2'd0;

  // Major opcodes in instr[6:0]
  localparam opcode_t op_op        = 7'b0110011;
  localparam opcode_t op_32_op     = 7'b0111011;
  localparam opcode_t op_imm_op    = 7'b0010011;
  localparam opcode_t op_imm_32_op = 7'b0011011;
  localparam opcode_t lui_op       = 7'b0110111;
  localparam opcode_t auipc_op     = 7'b0010111;
  localparam opcode_t jal_op       = 7'b1101111;
  localparam opcode_t jalr_op      = 7'b1100111;
  localparam opcode_t branch_op    = 7'b1100011;
  localparam opcode_t load_op      = 7'b0000011;
  localparam opcode_t store_op     = 7'b0100011;
  localparam opcode_t system_op    = 7'b1110011;

  typedef enum logic [2:0]
  {
    pipe_none,
    pipe_int,
    pipe_mul,
    pipe_long,
    pipe_ctl,
    pipe_mem_early,
    pipe_mem_final,
    pipe_sys
  } pipe_e;

  // Multiply, load and store groups are laid out in funct3 order
  typedef enum logic [5:0]
  {
    op_none = 6'd0,
    op_add,
    op_sub,
    op_sll,
    op_srl,
    op_sra,
    op_slt,
    op_sltu,
    op_xor,
    op_or,
    op_and,
    op_pass_src2,
    op_imul,
    op_mulh,
    op_mulhsu,
    op_mulhu,
    op_div,
    op_divu,
    op_rem,
    op_remu,
    op_jal,
    op_jalr,
    op_beq,
    op_bne,
    op_blt,
    op_bge,
    op_bltu,
    op_bgeu,
    op_lb,
    op_lh,
    op_lw,
    op_ld,
    op_lbu,
    op_lhu,
    op_lwu,
    op_sb,
    op_sh,
    op_sw,
    op_sd,
    op_ecall,
    op_ebreak,
    op_mret,
    op_sret,
    op_wfi
  } fu_op_e;

  typedef enum logic {src1_rs1, src1_pc} src1_sel_e;
  typedef enum logic {src2_rs2, src2_imm} src2_sel_e;
  typedef enum logic {baddr_pc, baddr_rs1} baddr_sel_e;

endpackage
